//--- cpu.f
+incdir+hw
hw/cpu_pkg.sv
hw/memctrl.sv
hw/fetcher.sv
hw/execute.sv
hw/cpu.sv
tests/cpu_checker.sv
tests/tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_cpu
FILELIST  ?= cpu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/tb_cpu.sv
// program table encoded into a byte memory with expected output from an ISA model
// memory answers one rdy_in-high cycle after the address and does not store i/o space
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module tb_cpu;

    localparam int SEED         = 49198;
    localparam int MAX_ROWS     = 64;
    localparam int RESET_CYCLES = 10;

    logic        clk_in = 1'b0;
    logic        rst_n = 1'b0;
    logic        rdy_in;
    logic        io_buffer_full;
    logic [7:0]  mem_din;
    wire  [7:0]  mem_dout;
    wire  [31:0] mem_a;
    wire         mem_wr;
    wire  [31:0] dbgreg_dout;

    cpu_pkg::op_e row_op [MAX_ROWS];
    logic [4:0]   row_rd [MAX_ROWS];
    logic [4:0]   row_rs1 [MAX_ROWS];
    logic [4:0]   row_rs2 [MAX_ROWS];
    logic [31:0]  row_imm [MAX_ROWS];
    int           n_rows = 0;
    logic [7:0]   exp_bytes [MAX_ROWS];
    int           exp_n = 0;

    logic [7:0]  mem [0:`CPU_MEM_TOP-1];
    logic [7:0]  model_mem [0:4095];
    logic [16:0] rd_addr = '0;
    logic        pressure_on = 1'b0;
    logic        built = 1'b0;
    logic        end_check = 1'b0;
    int          error_count;
    int          out_count;
    logic        stopped;
    string       stage = "reset";

    cpu dut (
        .clk_in         (clk_in),
        .rst_n          (rst_n),
        .rdy_in         (rdy_in),
        .mem_din        (mem_din),
        .mem_dout       (mem_dout),
        .mem_a          (mem_a),
        .mem_wr         (mem_wr),
        .io_buffer_full (io_buffer_full),
        .dbgreg_dout    (dbgreg_dout)
    );

    cpu_checker chk (
        .clk_in         (clk_in),
        .rst_n          (rst_n),
        .rdy_in         (rdy_in),
        .io_buffer_full (io_buffer_full),
        .mem_a          (mem_a),
        .mem_dout       (mem_dout),
        .mem_wr         (mem_wr),
        .dbgreg_dout    (dbgreg_dout),
        .end_check      (end_check),
        .error_count    (error_count),
        .out_count      (out_count),
        .stopped        (stopped)
    );

    always #50 clk_in = ~clk_in;

    task automatic add_row(input cpu_pkg::op_e op, input int rd, input int rs1,
                           input int rs2, input int imm);
        row_op[n_rows]  = op;
        row_rd[n_rows]  = 5'(rd);
        row_rs1[n_rows] = 5'(rs1);
        row_rs2[n_rows] = 5'(rs2);
        row_imm[n_rows] = 32'(imm);
        n_rows = n_rows + 1;
    endtask

    // RV32I encodings straight from the ISA formats
    function automatic logic [31:0] encode(input cpu_pkg::op_e op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [31:0] imm);
        logic [31:0] w;
        case (op)
            cpu_pkg::OP_LUI:  w = {imm[31:12], rd, 7'b0110111};
            cpu_pkg::OP_ADDI: w = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            cpu_pkg::OP_XORI: w = {imm[11:0], rs1, 3'b100, rd, 7'b0010011};
            cpu_pkg::OP_ORI:  w = {imm[11:0], rs1, 3'b110, rd, 7'b0010011};
            cpu_pkg::OP_ANDI: w = {imm[11:0], rs1, 3'b111, rd, 7'b0010011};
            cpu_pkg::OP_ADD:  w = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            cpu_pkg::OP_SUB:  w = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            cpu_pkg::OP_XOR:  w = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            cpu_pkg::OP_OR:   w = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            cpu_pkg::OP_AND:  w = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            cpu_pkg::OP_BEQ:  w = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11],
                                   7'b1100011};
            cpu_pkg::OP_BNE:  w = {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11],
                                   7'b1100011};
            cpu_pkg::OP_JAL:  w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            cpu_pkg::OP_LB:   w = {imm[11:0], rs1, 3'b000, rd, 7'b0000011};
            cpu_pkg::OP_LBU:  w = {imm[11:0], rs1, 3'b100, rd, 7'b0000011};
            cpu_pkg::OP_SB:   w = {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'b0100011};
            default:          w = 32'h0000_0013;
        endcase
        return w;
    endfunction

    // reference interpreter over the table that fills exp_bytes
    task automatic run_model();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] nxt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ad;
        int          idx;
        int          steps;
        logic        done;
        for (int i = 0; i < 32; i++)
            x[i] = '0;
        for (int i = 0; i < 4096; i++)
            model_mem[i] = '0;
        pc = `CPU_RESET_PC;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 1000) begin
            idx = int'(pc >> 2);
            a = x[row_rs1[idx]];
            b = x[row_rs2[idx]];
            ad = a + row_imm[idx];
            nxt = pc + 32'd4;
            case (row_op[idx])
                cpu_pkg::OP_LUI:  x[row_rd[idx]] = row_imm[idx];
                cpu_pkg::OP_ADDI: x[row_rd[idx]] = a + row_imm[idx];
                cpu_pkg::OP_ANDI: x[row_rd[idx]] = a & row_imm[idx];
                cpu_pkg::OP_ORI:  x[row_rd[idx]] = a | row_imm[idx];
                cpu_pkg::OP_XORI: x[row_rd[idx]] = a ^ row_imm[idx];
                cpu_pkg::OP_ADD:  x[row_rd[idx]] = a + b;
                cpu_pkg::OP_SUB:  x[row_rd[idx]] = a - b;
                cpu_pkg::OP_AND:  x[row_rd[idx]] = a & b;
                cpu_pkg::OP_OR:   x[row_rd[idx]] = a | b;
                cpu_pkg::OP_XOR:  x[row_rd[idx]] = a ^ b;
                cpu_pkg::OP_BEQ:  if (a == b) nxt = pc + row_imm[idx];
                cpu_pkg::OP_BNE:  if (a != b) nxt = pc + row_imm[idx];
                cpu_pkg::OP_JAL: begin
                    x[row_rd[idx]] = pc + 32'd4;
                    nxt = pc + row_imm[idx];
                end
                cpu_pkg::OP_LB:
                    x[row_rd[idx]] = {{24{model_mem[ad[11:0]][7]}}, model_mem[ad[11:0]]};
                cpu_pkg::OP_LBU:  x[row_rd[idx]] = {24'h0, model_mem[ad[11:0]]};
                cpu_pkg::OP_SB: begin
                    if (ad == `CPU_IO_STOP) begin
                        done = 1'b1;
                    end else if (ad == `CPU_IO_PORT) begin
                        // zero bytes never leave the port
                        if (b[7:0] != 8'h0) begin
                            exp_bytes[exp_n] = b[7:0];
                            exp_n = exp_n + 1;
                        end
                    end else begin
                        model_mem[ad[11:0]] = b[7:0];
                    end
                end
                default: ;
            endcase
            x[0] = '0;
            pc = nxt;
            steps = steps + 1;
        end
    endtask

    task automatic build_program();
        logic [31:0] w;
        // alu
        add_row(cpu_pkg::OP_LUI, 31, 0, 0, 32'h0003_0000);
        add_row(cpu_pkg::OP_ADDI, 1, 0, 0, 'h25);
        add_row(cpu_pkg::OP_ADDI, 2, 0, 0, 'h13);
        add_row(cpu_pkg::OP_ADD, 3, 1, 2, 0);
        add_row(cpu_pkg::OP_SB, 0, 31, 3, 0);
        add_row(cpu_pkg::OP_SUB, 4, 1, 2, 0);
        add_row(cpu_pkg::OP_SB, 0, 31, 4, 0);
        add_row(cpu_pkg::OP_AND, 5, 1, 2, 0);
        add_row(cpu_pkg::OP_SB, 0, 31, 5, 0);
        add_row(cpu_pkg::OP_OR, 6, 1, 2, 0);
        add_row(cpu_pkg::OP_SB, 0, 31, 6, 0);
        add_row(cpu_pkg::OP_XOR, 7, 1, 2, 0);
        add_row(cpu_pkg::OP_SB, 0, 31, 7, 0);
        add_row(cpu_pkg::OP_ANDI, 8, 1, 0, 'h0f);
        add_row(cpu_pkg::OP_SB, 0, 31, 8, 0);
        add_row(cpu_pkg::OP_ORI, 9, 1, 0, 'h40);
        add_row(cpu_pkg::OP_SB, 0, 31, 9, 0);
        add_row(cpu_pkg::OP_XORI, 10, 1, 0, -1);
        add_row(cpu_pkg::OP_SB, 0, 31, 10, 0);
        add_row(cpu_pkg::OP_LUI, 11, 0, 0, 32'h1234_5000);
        add_row(cpu_pkg::OP_ADDI, 11, 11, 0, 'h678);
        add_row(cpu_pkg::OP_SB, 0, 31, 11, 0);
        add_row(cpu_pkg::OP_SB, 0, 31, 0, 0);
        // skipped stores in the branch and jump rows must not appear
        add_row(cpu_pkg::OP_BEQ, 0, 1, 1, 8);
        add_row(cpu_pkg::OP_SB, 0, 31, 1, 0);
        add_row(cpu_pkg::OP_BNE, 0, 1, 2, 8);
        add_row(cpu_pkg::OP_SB, 0, 31, 2, 0);
        add_row(cpu_pkg::OP_BEQ, 0, 1, 2, 8);
        add_row(cpu_pkg::OP_SB, 0, 31, 2, 0);
        add_row(cpu_pkg::OP_BNE, 0, 1, 1, 8);
        add_row(cpu_pkg::OP_SB, 0, 31, 1, 0);
        add_row(cpu_pkg::OP_JAL, 12, 0, 0, 8);
        add_row(cpu_pkg::OP_SB, 0, 31, 3, 0);
        add_row(cpu_pkg::OP_SB, 0, 31, 12, 0);
        // byte loads from a scratch area
        add_row(cpu_pkg::OP_ADDI, 13, 0, 0, 'h400);
        add_row(cpu_pkg::OP_ADDI, 14, 0, 0, -'h7e);
        add_row(cpu_pkg::OP_SB, 0, 13, 14, 0);
        add_row(cpu_pkg::OP_SB, 0, 13, 12, 1);
        add_row(cpu_pkg::OP_LB, 15, 13, 0, 0);
        add_row(cpu_pkg::OP_LBU, 16, 13, 0, 0);
        add_row(cpu_pkg::OP_SB, 0, 31, 15, 0);
        add_row(cpu_pkg::OP_SB, 0, 31, 16, 0);
        // upper bits differ only if LB sign-extends
        add_row(cpu_pkg::OP_SUB, 17, 16, 15, 0);
        add_row(cpu_pkg::OP_ADDI, 18, 0, 0, 'h100);
        add_row(cpu_pkg::OP_BEQ, 0, 17, 18, 8);
        add_row(cpu_pkg::OP_SB, 0, 31, 1, 0);
        add_row(cpu_pkg::OP_SB, 0, 31, 4, 0);
        add_row(cpu_pkg::OP_LBU, 20, 13, 0, 1);
        add_row(cpu_pkg::OP_SB, 0, 31, 20, 0);
        // epilogue
        add_row(cpu_pkg::OP_SB, 0, 31, 0, 4);
        add_row(cpu_pkg::OP_JAL, 0, 0, 0, 0);
        for (int i = 0; i < `CPU_MEM_TOP; i++)
            mem[i] = 8'(i ^ (i >> 8) ^ (i >> 16));
        for (int i = 0; i < n_rows; i++) begin
            w = encode(row_op[i], row_rd[i], row_rs1[i], row_rs2[i], row_imm[i]);
            for (int k = 0; k < 4; k++)
                mem[4 * i + k] = w[8 * k +: 8];
        end
    endtask

    // memory takes the address on the rising edge and drives data on the falling one
    always @(posedge clk_in) begin
        if (rdy_in) begin
            rd_addr <= mem_a[16:0];
            if (mem_wr && mem_a[17:16] != 2'b11)
                mem[mem_a[16:0]] <= mem_dout;
        end
    end

    always @(negedge clk_in)
        mem_din <= mem[rd_addr];

    // random pauses and a full output buffer once the program runs
    initial begin
        void'($urandom(SEED));
        rdy_in = 1'b1;
        io_buffer_full = 1'b0;
        wait (pressure_on);
        forever begin
            @(negedge clk_in);
            rdy_in         <= ($urandom % 4) != 0;
            io_buffer_full <= ($urandom % 4) == 0;
        end
    end

    initial begin
        int limit;
        wait (built);
        limit = (n_rows * 40 + 200) * 4;
        repeat (limit) @(posedge clk_in);
        $display("timeout after %0d cycles, stage reached: %s", limit, stage);
        $display("sim failed");
        $finish;
    end

    initial begin
        mem_din = 8'h0;
        build_program();
        run_model();
        built = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk_in);
        rst_n = 1'b1;
        pressure_on = 1'b1;
        stage = "program running";
        while (!stopped)
            @(negedge clk_in);
        // any write after the stop is flagged by the checker
        stage = "after stop";
        repeat (100) @(negedge clk_in);
        end_check = 1'b1;
        repeat (2) @(negedge clk_in);
        $display("errors: %0d, output bytes: %0d of %0d", error_count, out_count, exp_n);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/cpu_checker.sv
// watches the memory port of the core and compares output bytes to tb_cpu.exp_bytes
// expects one program run whose stop write comes after the last output byte
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module cpu_checker (
    input  wire         clk_in,
    input  wire         rst_n,
    input  wire         rdy_in,
    input  wire         io_buffer_full,
    input  wire [31:0]  mem_a,
    input  wire [7:0]   mem_dout,
    input  wire         mem_wr,
    input  wire [31:0]  dbgreg_dout,
    input  wire         end_check,
    output int          error_count,
    output int          out_count,
    output logic        stopped
);

    int   errs = 0;
    int   outs = 0;
    logic seen_first = 1'b0;
    logic fetch_armed = 1'b0;
    logic pc_checked = 1'b0;
    logic count_done = 1'b0;
    logic stop_seen = 1'b0;

    assign error_count = errs;
    assign out_count   = outs;
    assign stopped     = stop_seen;

    always @(posedge clk_in) begin
        if (!rst_n) begin
            if (mem_wr) begin
                $display("mem_wr was high during reset");
                errs = errs + 1;
            end
            if (dbgreg_dout != 32'h0) begin
                $display("[FAIL] dbgreg_dout expected %h got %h", 32'h0, dbgreg_dout);
                errs = errs + 1;
            end
        end else begin
            // first cycle out of reset
            if (!seen_first) begin
                seen_first <= 1'b1;
                if (dbgreg_dout != 32'h0) begin
                    $display("[FAIL] dbgreg_dout expected %h got %h", 32'h0, dbgreg_dout);
                    errs = errs + 1;
                end
            end
            // reset fetch is accepted on the first rdy_in-high edge
            // and its address is on mem_a from the next edge on
            if (fetch_armed && !pc_checked) begin
                pc_checked <= 1'b1;
                if (mem_a != `CPU_RESET_PC) begin
                    $display("[FAIL] mem_a expected %h got %h", `CPU_RESET_PC, mem_a);
                    errs = errs + 1;
                end
            end
            if (rdy_in)
                fetch_armed <= 1'b1;
            if (mem_wr && !rdy_in) begin
                $display("mem_wr was high while rdy_in was low");
                errs = errs + 1;
            end
            if (mem_wr && stop_seen) begin
                $display("write to address %h after the stop write", mem_a);
                errs = errs + 1;
            end else if (mem_wr && mem_a == `CPU_IO_STOP) begin
                stop_seen <= 1'b1;
            end else if (mem_wr && mem_a == `CPU_IO_PORT) begin
                if (io_buffer_full) begin
                    $display("output write while io_buffer_full was high");
                    errs = errs + 1;
                end
                if (mem_dout == 8'h0) begin
                    $display("a zero byte reached the output port");
                    errs = errs + 1;
                end
                if (outs >= tb_cpu.exp_n) begin
                    $display("unexpected extra output byte %h", mem_dout);
                    errs = errs + 1;
                end else if (mem_dout != tb_cpu.exp_bytes[outs]) begin
                    $display("[FAIL] mem_dout expected %h got %h",
                             tb_cpu.exp_bytes[outs], mem_dout);
                    errs = errs + 1;
                end
                outs = outs + 1;
            end
            // count and stop must both be complete at the end of the run
            if (end_check && !count_done) begin
                count_done <= 1'b1;
                if (outs != tb_cpu.exp_n) begin
                    $display("got %0d output bytes but expected %0d", outs, tb_cpu.exp_n);
                    errs = errs + 1;
                end
                if (!stop_seen) begin
                    $display("the stop write never happened");
                    errs = errs + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/cpu.sv
// rv32i subset core behind the byte-wide memory port
// whole core pauses while rdy_in is low; only mem_a[17:0] reaches memory
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module cpu (
    input  wire                    clk_in,
    input  wire                    rst_n,
    input  wire                    rdy_in,
    input  wire [`CPU_BYTE_W-1:0]  mem_din,
    output wire [`CPU_BYTE_W-1:0]  mem_dout,
    output wire [`CPU_ADDR_W-1:0]  mem_a,
    output wire                    mem_wr,
    input  wire                    io_buffer_full,
    output wire [`CPU_XLEN-1:0]    dbgreg_dout
);

    // fetch path
    wire                    fetch_en;
    wire [`CPU_ADDR_W-1:0]  fetch_pc;
    wire                    fetch_done;
    wire [`CPU_XLEN-1:0]    fetch_inst;
    wire                    halted;
    // fetcher to execute
    wire                    inst_valid;
    wire cpu_pkg::inst_t    inst;
    wire                    next_pc_en;
    wire [`CPU_ADDR_W-1:0]  next_pc;
    // data path
    wire                    data_en;
    wire cpu_pkg::mem_req_t data_req;
    wire                    data_done;
    wire [`CPU_XLEN-1:0]    data_rdata;

    memctrl u_memctrl (
        .clk_in         (clk_in),
        .rst_n          (rst_n),
        .rdy_in         (rdy_in),
        .io_buffer_full (io_buffer_full),
        .mem_din        (mem_din),
        .mem_dout       (mem_dout),
        .mem_a          (mem_a),
        .mem_wr         (mem_wr),
        .fetch_en       (fetch_en),
        .fetch_pc       (fetch_pc),
        .fetch_done     (fetch_done),
        .fetch_inst     (fetch_inst),
        .data_en        (data_en),
        .data_req       (data_req),
        .data_done      (data_done),
        .data_rdata     (data_rdata),
        .halted         (halted)
    );

    fetcher u_fetcher (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .rdy_in     (rdy_in),
        .halted     (halted),
        .fetch_done (fetch_done),
        .fetch_inst (fetch_inst),
        .next_pc_en (next_pc_en),
        .next_pc    (next_pc),
        .fetch_en   (fetch_en),
        .fetch_pc   (fetch_pc),
        .inst_valid (inst_valid),
        .inst       (inst)
    );

    execute u_execute (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .rdy_in      (rdy_in),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .data_done   (data_done),
        .data_rdata  (data_rdata),
        .data_en     (data_en),
        .data_req    (data_req),
        .next_pc_en  (next_pc_en),
        .next_pc     (next_pc),
        .dbgreg_dout (dbgreg_dout)
    );

endmodule

`default_nettype wire

//--- hw/execute.sv
// register file, alu and branch resolution for one instruction at a time
// every instruction retires through next_pc_en, loads and stores after data_done
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module execute (
    input  wire                    clk_in,
    input  wire                    rst_n,
    input  wire                    rdy_in,
    input  wire                    inst_valid,
    input  wire cpu_pkg::inst_t    inst,
    input  wire                    data_done,
    input  wire [`CPU_XLEN-1:0]    data_rdata,
    output wire                    data_en,
    output cpu_pkg::mem_req_t      data_req,
    output wire                    next_pc_en,
    output wire [`CPU_ADDR_W-1:0]  next_pc,
    output logic [`CPU_XLEN-1:0]   dbgreg_dout
);

    logic [`CPU_XLEN-1:0] regs [32];
    cpu_pkg::ex_state_e   state;
    cpu_pkg::inst_t       cur;
    logic [`CPU_XLEN-1:0] a;
    logic [`CPU_XLEN-1:0] b;
    logic [`CPU_XLEN-1:0] alu;
    logic                 taken;
    logic                 is_mem;
    logic                 wb_en;
    logic [`CPU_XLEN-1:0] wb_val;

    // x0 reads as zero
    assign a = (cur.rs1 == 5'd0) ? '0 : regs[cur.rs1];
    assign b = (cur.rs2 == 5'd0) ? '0 : regs[cur.rs2];

    always_comb begin
        alu   = '0;
        taken = 1'b0;
        case (cur.op)
            cpu_pkg::OP_LUI:  alu = cur.imm;
            cpu_pkg::OP_ADDI: alu = a + cur.imm;
            cpu_pkg::OP_ANDI: alu = a & cur.imm;
            cpu_pkg::OP_ORI:  alu = a | cur.imm;
            cpu_pkg::OP_XORI: alu = a ^ cur.imm;
            cpu_pkg::OP_ADD:  alu = a + b;
            cpu_pkg::OP_SUB:  alu = a - b;
            cpu_pkg::OP_AND:  alu = a & b;
            cpu_pkg::OP_OR:   alu = a | b;
            cpu_pkg::OP_XOR:  alu = a ^ b;
            cpu_pkg::OP_BEQ:  taken = (a == b);
            cpu_pkg::OP_BNE:  taken = (a != b);
            cpu_pkg::OP_JAL: begin
                // link value
                alu   = cur.pc + 32'd4;
                taken = 1'b1;
            end
            default: alu = '0;
        endcase
    end

    assign is_mem = cur.op inside {cpu_pkg::OP_LB, cpu_pkg::OP_LBU, cpu_pkg::OP_SB};

    // alu results land in RUN, load bytes when memctrl answers
    assign wb_en = ((state == cpu_pkg::EX_RUN) && !is_mem
                    && !(cur.op inside {cpu_pkg::OP_NOP, cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE}))
                   || ((state == cpu_pkg::EX_MEM) && data_done && cur.op != cpu_pkg::OP_SB);
    assign wb_val = (state == cpu_pkg::EX_MEM) ? data_rdata : alu;

    assign data_en  = (state == cpu_pkg::EX_RUN) && is_mem;
    assign data_req = '{addr:        a + cur.imm,
                        wdata:       b[`CPU_BYTE_W-1:0],
                        is_write:    cur.op == cpu_pkg::OP_SB,
                        signed_load: cur.op == cpu_pkg::OP_LB};

    assign next_pc_en = ((state == cpu_pkg::EX_RUN) && !is_mem)
                        || (state == cpu_pkg::EX_REDIRECT);
    assign next_pc    = taken ? cur.pc + cur.imm : cur.pc + 32'd4;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state       <= cpu_pkg::EX_WAIT_INST;
            dbgreg_dout <= '0;
        end else if (rdy_in) begin
            case (state)
                cpu_pkg::EX_WAIT_INST: begin
                    if (inst_valid)
                        state <= cpu_pkg::EX_RUN;
                end
                cpu_pkg::EX_RUN: state <= is_mem ? cpu_pkg::EX_MEM : cpu_pkg::EX_WAIT_INST;
                cpu_pkg::EX_MEM: begin
                    if (data_done)
                        state <= cpu_pkg::EX_REDIRECT;
                end
                default: state <= cpu_pkg::EX_WAIT_INST;
            endcase
            if (wb_en && cur.rd != 5'd0)
                dbgreg_dout <= wb_val;
        end
    end

    // current instruction and register file
    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (state == cpu_pkg::EX_WAIT_INST && inst_valid)
                cur <= inst;
            if (wb_en && cur.rd != 5'd0)
                regs[cur.rd] <= wb_val;
        end
    end

    // only byte loads and stores reach memctrl
    assert property (@(posedge clk_in) disable iff (!rst_n)
        data_en |-> cur.op inside {cpu_pkg::OP_LB, cpu_pkg::OP_LBU, cpu_pkg::OP_SB});

endmodule

`default_nettype wire

//--- hw/fetcher.sv
// holds the pc and fetches the next word only after execute retires
// unknown encodings decode to OP_NOP
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module fetcher (
    input  wire                    clk_in,
    input  wire                    rst_n,
    input  wire                    rdy_in,
    input  wire                    halted,
    input  wire                    fetch_done,
    input  wire [`CPU_XLEN-1:0]    fetch_inst,
    input  wire                    next_pc_en,
    input  wire [`CPU_ADDR_W-1:0]  next_pc,
    output wire                    fetch_en,
    output wire [`CPU_ADDR_W-1:0]  fetch_pc,
    output logic                   inst_valid,
    output cpu_pkg::inst_t         inst
);

    logic [`CPU_ADDR_W-1:0] pc;
    logic                   fetch_req;

    function automatic cpu_pkg::inst_t decode(input logic [`CPU_XLEN-1:0] w,
                                              input logic [`CPU_ADDR_W-1:0] at);
        cpu_pkg::inst_t d;
        logic [2:0]     f3;
        f3    = w[14:12];
        d.op  = cpu_pkg::OP_NOP;
        d.rd  = w[11:7];
        d.rs1 = w[19:15];
        d.rs2 = w[24:20];
        d.pc  = at;
        // I-type by default
        d.imm = {{20{w[31]}}, w[31:20]};
        case (w[6:0])
            7'b0110111: begin
                d.op  = cpu_pkg::OP_LUI;
                d.imm = {w[31:12], 12'b0};
            end
            7'b0010011: begin
                case (f3)
                    3'b000: d.op = cpu_pkg::OP_ADDI;
                    3'b100: d.op = cpu_pkg::OP_XORI;
                    3'b110: d.op = cpu_pkg::OP_ORI;
                    3'b111: d.op = cpu_pkg::OP_ANDI;
                    default: d.op = cpu_pkg::OP_NOP;
                endcase
            end
            7'b0110011: begin
                // funct7 bit 5 splits add from sub
                case ({w[30], f3})
                    4'b0000: d.op = cpu_pkg::OP_ADD;
                    4'b1000: d.op = cpu_pkg::OP_SUB;
                    4'b0100: d.op = cpu_pkg::OP_XOR;
                    4'b0110: d.op = cpu_pkg::OP_OR;
                    4'b0111: d.op = cpu_pkg::OP_AND;
                    default: d.op = cpu_pkg::OP_NOP;
                endcase
            end
            7'b1100011: begin
                d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                if (f3 == 3'b000)
                    d.op = cpu_pkg::OP_BEQ;
                else if (f3 == 3'b001)
                    d.op = cpu_pkg::OP_BNE;
            end
            7'b1101111: begin
                d.op  = cpu_pkg::OP_JAL;
                d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b0000011: begin
                if (f3 == 3'b000)
                    d.op = cpu_pkg::OP_LB;
                else if (f3 == 3'b100)
                    d.op = cpu_pkg::OP_LBU;
            end
            7'b0100011: begin
                d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
                if (f3 == 3'b000)
                    d.op = cpu_pkg::OP_SB;
            end
            default: d.op = cpu_pkg::OP_NOP;
        endcase
        return d;
    endfunction

    assign fetch_en = fetch_req && !halted;
    assign fetch_pc = pc;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            pc         <= `CPU_RESET_PC;
            fetch_req  <= 1'b1;
            inst_valid <= 1'b0;
        end else if (rdy_in) begin
            inst_valid <= fetch_done;
            if (fetch_done)
                fetch_req <= 1'b0;
            if (next_pc_en) begin
                pc        <= next_pc;
                fetch_req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && fetch_done)
            inst <= decode(fetch_inst, pc);
    end

    // one instruction handed over per retirement
    assert property (@(posedge clk_in) disable iff (!rst_n)
        inst_valid && rdy_in |=> !inst_valid until next_pc_en);

endmodule

`default_nettype wire

//--- hw/memctrl.sv
// byte-serial memory port serving one request at a time with data ahead of fetch
// stores to the output port wait on io_buffer_full and never strobe for a zero byte
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module memctrl (
    input  wire                    clk_in,
    input  wire                    rst_n,
    input  wire                    rdy_in,
    input  wire                    io_buffer_full,
    input  wire [`CPU_BYTE_W-1:0]  mem_din,
    output wire [`CPU_BYTE_W-1:0]  mem_dout,
    output wire [`CPU_ADDR_W-1:0]  mem_a,
    output wire                    mem_wr,
    input  wire                    fetch_en,
    input  wire [`CPU_ADDR_W-1:0]  fetch_pc,
    output wire                    fetch_done,
    output wire [`CPU_XLEN-1:0]    fetch_inst,
    input  wire                    data_en,
    input  wire cpu_pkg::mem_req_t data_req,
    output wire                    data_done,
    output wire [`CPU_XLEN-1:0]    data_rdata,
    output logic                   halted
);

    cpu_pkg::mc_state_e     state;
    logic [2:0]             cnt;
    logic [`CPU_ADDR_W-1:0] addr_q;
    cpu_pkg::mem_req_t      req_q;
    logic [23:0]            byte_buf;
    logic                   store_go;

    // output writes hold while the uart side is full
    assign store_go = (state == cpu_pkg::MC_STORE)
                      && !(req_q.addr == `CPU_IO_PORT && io_buffer_full);

    assign mem_a    = addr_q;
    assign mem_dout = req_q.wdata;
    assign mem_wr   = rdy_in && store_go
                      && !(req_q.addr == `CPU_IO_PORT && req_q.wdata == '0);

    // last byte is taken straight off mem_din
    assign fetch_done = (state == cpu_pkg::MC_FETCH) && (cnt == 3'd4);
    assign fetch_inst = {mem_din, byte_buf};
    assign data_done  = store_go || ((state == cpu_pkg::MC_LOAD) && (cnt == 3'd1));
    assign data_rdata = req_q.signed_load
                        ? {{(`CPU_XLEN-`CPU_BYTE_W){mem_din[`CPU_BYTE_W-1]}}, mem_din}
                        : {{(`CPU_XLEN-`CPU_BYTE_W){1'b0}}, mem_din};

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state  <= cpu_pkg::MC_IDLE;
            cnt    <= '0;
            addr_q <= '0;
            halted <= 1'b0;
        end else if (rdy_in) begin
            case (state)
                cpu_pkg::MC_IDLE: begin
                    cnt <= '0;
                    if (data_en) begin
                        addr_q <= data_req.addr;
                        state  <= data_req.is_write ? cpu_pkg::MC_STORE : cpu_pkg::MC_LOAD;
                    end else if (fetch_en && !halted) begin
                        addr_q <= fetch_pc;
                        state  <= cpu_pkg::MC_FETCH;
                    end
                end
                cpu_pkg::MC_FETCH: begin
                    cnt <= cnt + 3'd1;
                    // stop at pc+3 so mem_din keeps the last byte
                    if (cnt < 3'd3)
                        addr_q <= addr_q + 32'd1;
                    if (fetch_done)
                        state <= cpu_pkg::MC_IDLE;
                end
                cpu_pkg::MC_LOAD: begin
                    cnt <= cnt + 3'd1;
                    if (data_done)
                        state <= cpu_pkg::MC_IDLE;
                end
                cpu_pkg::MC_STORE: begin
                    if (store_go) begin
                        state <= cpu_pkg::MC_IDLE;
                        if (req_q.addr == `CPU_IO_STOP)
                            halted <= 1'b1;
                    end
                end
                default: state <= cpu_pkg::MC_IDLE;
            endcase
        end
    end

    // request and instruction bytes
    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (state == cpu_pkg::MC_IDLE && data_en)
                req_q <= data_req;
            // bytes 0..2, each one cycle behind its address
            if (state == cpu_pkg::MC_FETCH && cnt != 3'd0 && cnt != 3'd4)
                byte_buf <= {mem_din, byte_buf[23:8]};
        end
    end

    // no write strobe during a pause
    assert property (@(posedge clk_in) disable iff (!rst_n) !rdy_in |-> !mem_wr);

    // fetch and data never complete in the same cycle
    assert property (@(posedge clk_in) disable iff (!rst_n) !(fetch_done && data_done));

    // program stays inside memory
    assert property (@(posedge clk_in) disable iff (!rst_n)
        fetch_en |-> fetch_pc < `CPU_MEM_TOP);

endmodule

`default_nettype wire

//--- hw/cpu_pkg.sv
// types shared by fetcher, execute and memctrl
// one instruction in flight, so requests carry no tags
`default_nettype none
`include "cpu_consts.svh"

package cpu_pkg;

    // supported operations, every other encoding is OP_NOP
    typedef enum logic [4:0] {
        OP_NOP,
        OP_LUI,
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_BEQ, OP_BNE, OP_JAL,
        OP_LB, OP_LBU, OP_SB
    } op_e;

    // decoded instruction handed from fetcher to execute
    typedef struct packed {
        op_e                    op;
        logic [4:0]             rd;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic [`CPU_XLEN-1:0]   imm;
        logic [`CPU_ADDR_W-1:0] pc;
    } inst_t;

    // single byte data access
    typedef struct packed {
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_BYTE_W-1:0] wdata;
        logic                   is_write;
        logic                   signed_load;
    } mem_req_t;

    typedef enum logic [1:0] {
        MC_IDLE,
        MC_FETCH,
        MC_LOAD,
        MC_STORE
    } mc_state_e;

    typedef enum logic [1:0] {
        EX_WAIT_INST,
        EX_RUN,
        EX_MEM,
        EX_REDIRECT
    } ex_state_e;

endpackage

`default_nettype wire

//--- hw/cpu_consts.svh
// address map and bus widths shared by the core and its testbench
// memory is 128 KB, i/o lives where address bits 17:16 are both set
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// bus widths
`define CPU_ADDR_W 32
`define CPU_XLEN   32
`define CPU_BYTE_W 8

// memory size, valid addresses below this
`define CPU_MEM_TOP 32'h0002_0000

// i/o addresses
`define CPU_IO_PORT 32'h0003_0000
`define CPU_IO_STOP 32'h0003_0004

// first fetch address out of reset
`define CPU_RESET_PC 32'h0000_0000

`endif
